//--- mfifoPkg.sv
// ==================================================
// Multi-FIFO package with the width helpers and
// the default sizes of the shared-storage FIFO
// ==================================================

package mfifoPkg;

  // Default geometry, applied by the top level and passed down
  localparam int DefaultNumFifos = 4;
  localparam int DefaultDepth = 16;
  localparam int DefaultWidth = 16;
  localparam int DefaultStagingDepth = 2;
  localparam int DefaultRamReadLatency = 1;

  // Ceiling log2 that never drops below one bit, for addresses and FIFO IDs
  function automatic int clampedClog2(input int value);
    return (value < 2) ? 1 : $clog2(value);
  endfunction

  // Bits needed to count from zero up to and including the given depth
  function automatic int countWidthF(input int depth);
    return (depth < 1) ? 1 : $clog2(depth + 1);
  endfunction

endpackage

//--- mfifoSizeCalc.sv
// ==================================================
// Size calculator: registers the size of every
// logical FIFO and checks the address windows
// ==================================================
`timescale 1ns/1ps

module mfifoSizeCalc #(
  parameter int NumFifos = 2,
  parameter int Depth = 2,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int CountWidth = mfifoPkg::countWidthF(Depth)
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [NumFifos-1:0][AddrWidth-1:0]  configBase,
  input  logic [NumFifos-1:0][AddrWidth-1:0]  configBound,
  output logic [NumFifos-1:0][CountWidth-1:0] configSize,
  output logic                                 configError
);

  logic [NumFifos-1:0][CountWidth-1:0] sizeNext;
  logic errorNext;

  always_comb begin
    errorNext = 1'b0;
    for (int i = 0; i < NumFifos; i++) begin
      // Both limits are inclusive, so a window of one address has size one
      sizeNext[i] = CountWidth'(configBound[i]) - CountWidth'(configBase[i]) + 1'b1;
      // Every window must sit inside the RAM and must not be inverted
      if (int'(configBound[i]) >= Depth || configBase[i] > configBound[i]) begin
        errorNext = 1'b1;
      end
    end
    // Windows are laid out in ascending order without any overlap
    for (int i = 1; i < NumFifos; i++) begin
      if (configBase[i] <= configBound[i-1]) begin
        errorNext = 1'b1;
      end
    end
  end

  // Register the size of every window for the pointer manager
  always_ff @(posedge clk) begin
    configSize <= sizeNext;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      configError <= 1'b0;
    end else begin
      configError <= errorNext;
    end
  end

endmodule

//--- mfifoPushCtrl.sv
// ==================================================
// Push controller: turns credited pushes into RAM
// writes and returns one credit per freed slot
// ==================================================
`timescale 1ns/1ps

module mfifoPushCtrl #(
  parameter int NumFifos = 2,
  parameter int Depth = 2,
  parameter int Width = 1,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int FifoIdWidth = mfifoPkg::clampedClog2(NumFifos)
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                pushValid,
  input  logic [FifoIdWidth-1:0]              pushFifoId,
  input  logic [Width-1:0]                    pushData,
  input  logic [NumFifos-1:0]                 deallocValid,
  input  logic [NumFifos-1:0][AddrWidth-1:0] tail,
  output logic [NumFifos-1:0]                 pushCredit,
  output logic                                ramWrValid,
  output logic [AddrWidth-1:0]                ramWrAddr,
  output logic [Width-1:0]                    ramWrData,
  output logic [NumFifos-1:0]                 advanceTail
);

  // High for a push that names a FIFO which does not exist
  logic pushIdBad;

  assign pushIdBad = pushValid && (int'(pushFifoId) >= NumFifos);

  // A push with a bad ID is dropped and never reaches the RAM
  assign ramWrValid = pushValid && !pushIdBad;
  assign ramWrData = pushData;

  // Decode the ID into a tail advance and pick that FIFO's tail as address
  always_comb begin
    advanceTail = '0;
    ramWrAddr = tail[0];
    for (int i = 0; i < NumFifos; i++) begin
      if (pushFifoId == FifoIdWidth'(i)) begin
        advanceTail[i] = ramWrValid;
        ramWrAddr = tail[i];
      end
    end
  end

  // Each pop frees one slot and the credit goes back one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      pushCredit <= '0;
    end else begin
      pushCredit <= deallocValid;
    end
  end

endmodule

//--- mfifoPtrMgr.sv
// ==================================================
// Pointer manager: head, tail and item count per
// logical FIFO, each pointer wrapping in its window
// ==================================================
`timescale 1ns/1ps

module mfifoPtrMgr #(
  parameter int NumFifos = 2,
  parameter int Depth = 2,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int CountWidth = mfifoPkg::countWidthF(Depth)
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [NumFifos-1:0][AddrWidth-1:0]  configBase,
  input  logic [NumFifos-1:0][AddrWidth-1:0]  configBound,
  input  logic [NumFifos-1:0][CountWidth-1:0] configSize,
  input  logic [NumFifos-1:0]                  advanceTail,
  input  logic [NumFifos-1:0]                  headReady,
  input  logic [NumFifos-1:0][CountWidth-1:0] stagedCount,
  output logic [NumFifos-1:0][AddrWidth-1:0]  tail,
  output logic [NumFifos-1:0][AddrWidth-1:0]  head,
  output logic [NumFifos-1:0]                  headValid,
  output logic [NumFifos-1:0]                  pushFull,
  output logic [NumFifos-1:0]                  ramEmpty
);

  for (genvar i = 0; i < NumFifos; i++) begin : gFifo
    logic [AddrWidth-1:0] tailReg;
    logic [AddrWidth-1:0] headReg;
    logic [CountWidth-1:0] ramItems;
    logic readIssue;

    // The pop controller only takes the head while it is valid
    assign readIssue = headValid[i] && headReady[i];

    always_ff @(posedge clk) begin
      if (reset) begin
        // The window base is stable before reset is released
        tailReg <= configBase[i];
        headReg <= configBase[i];
        ramItems <= '0;
      end else begin
        if (advanceTail[i]) begin
          tailReg <= (tailReg == configBound[i]) ? configBase[i] : tailReg + 1'b1;
        end
        if (readIssue) begin
          headReg <= (headReg == configBound[i]) ? configBase[i] : headReg + 1'b1;
        end
        ramItems <= ramItems + CountWidth'(advanceTail[i]) - CountWidth'(readIssue);
      end
    end

    assign tail[i] = tailReg;
    assign head[i] = headReg;
    assign headValid[i] = (ramItems != '0);
    assign ramEmpty[i] = (ramItems == '0);

    // Staged entries still hold their RAM slot until they are popped
    assign pushFull[i] = ((ramItems + stagedCount[i]) == configSize[i]);
  end

endmodule

//--- mfifoPopCtrl.sv
// ==================================================
// Pop controller: LRU arbitration of the RAM read
// port and per-FIFO staging buffers for the pops
// ==================================================
`timescale 1ns/1ps

module mfifoPopCtrl #(
  parameter int NumFifos = 2,
  parameter int Depth = 2,
  parameter int Width = 1,
  parameter int StagingBufferDepth = 1,
  parameter int RamReadLatency = 0,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int CountWidth = mfifoPkg::countWidthF(Depth),
  localparam int IdWidth = mfifoPkg::clampedClog2(NumFifos)
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [NumFifos-1:0]                  headValid,
  input  logic [NumFifos-1:0][AddrWidth-1:0]  head,
  input  logic [NumFifos-1:0]                  ramEmpty,
  input  logic [NumFifos-1:0]                  popReady,
  input  logic                                 ramRdDataValid,
  input  logic [Width-1:0]                     ramRdData,
  output logic [NumFifos-1:0]                  headReady,
  output logic [NumFifos-1:0][CountWidth-1:0] stagedCount,
  output logic [NumFifos-1:0]                  popValid,
  output logic [NumFifos-1:0][Width-1:0]      popData,
  output logic [NumFifos-1:0]                  popEmpty,
  output logic [NumFifos-1:0]                  deallocValid,
  output logic                                 ramRdAddrValid,
  output logic [AddrWidth-1:0]                 ramRdAddr
);

  import mfifoPkg::*;

  localparam int PtrWidth = clampedClog2(StagingBufferDepth);
  localparam int StageCntWidth = countWidthF(StagingBufferDepth);

  logic [NumFifos-1:0] request;
  logic grantValid;
  logic [IdWidth-1:0] grantId;
  logic [IdWidth-1:0] grantPos;
  logic [IdWidth-1:0] returnId;

  // Order list of FIFO IDs, entry zero is the least recently granted
  logic [NumFifos-1:0][IdWidth-1:0] lruOrder;

  // Scan from the back so the requester nearest the front wins
  always_comb begin
    grantValid = 1'b0;
    grantId = '0;
    grantPos = '0;
    for (int k = NumFifos - 1; k >= 0; k--) begin
      if (request[lruOrder[k]]) begin
        grantValid = 1'b1;
        grantId = lruOrder[k];
        grantPos = IdWidth'(k);
      end
    end
  end

  // The granted ID moves to the back and the entries behind it close the gap
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < NumFifos; k++) begin
        lruOrder[k] <= IdWidth'(k);
      end
    end else if (grantValid) begin
      for (int k = 0; k < NumFifos - 1; k++) begin
        if (k >= int'(grantPos)) begin
          lruOrder[k] <= lruOrder[k+1];
        end
      end
      lruOrder[NumFifos-1] <= grantId;
    end
  end

  assign ramRdAddrValid = grantValid;
  assign ramRdAddr = head[grantId];

  // Remember which FIFO each read belongs to until its data comes back
  if (RamReadLatency == 0) begin : gNoDelay
    assign returnId = grantId;
  end else begin : gDelay
    logic [RamReadLatency-1:0][IdWidth-1:0] idPipe;

    always_ff @(posedge clk) begin
      idPipe[0] <= grantId;
      for (int s = 1; s < RamReadLatency; s++) begin
        idPipe[s] <= idPipe[s-1];
      end
    end

    assign returnId = idPipe[RamReadLatency-1];
  end

  for (genvar i = 0; i < NumFifos; i++) begin : gStage
    logic [Width-1:0] stageMem [StagingBufferDepth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [StageCntWidth-1:0] stageCount;
    // Entries held in the buffer plus reads still in flight
    logic [StageCntWidth-1:0] reserved;
    logic fill;
    logic pop;

    assign fill = ramRdDataValid && (returnId == IdWidth'(i));
    assign pop = popValid[i] && popReady[i];

    // Only ask for a read when the buffer can take its data on return
    assign request[i] = headValid[i] && (reserved != StageCntWidth'(StagingBufferDepth));
    assign headReady[i] = grantValid && (grantId == IdWidth'(i));

    always_ff @(posedge clk) begin
      if (reset) begin
        wrPtr <= '0;
        rdPtr <= '0;
        stageCount <= '0;
        reserved <= '0;
      end else begin
        if (fill) begin
          wrPtr <= (wrPtr == PtrWidth'(StagingBufferDepth - 1)) ? '0 : wrPtr + 1'b1;
        end
        if (pop) begin
          rdPtr <= (rdPtr == PtrWidth'(StagingBufferDepth - 1)) ? '0 : rdPtr + 1'b1;
        end
        stageCount <= stageCount + StageCntWidth'(fill) - StageCntWidth'(pop);
        reserved <= reserved + StageCntWidth'(headReady[i]) - StageCntWidth'(pop);
      end
    end

    always_ff @(posedge clk) begin
      if (fill) begin
        stageMem[wrPtr] <= ramRdData;
      end
    end

    assign popValid[i] = (stageCount != '0);
    assign popData[i] = stageMem[rdPtr];
    assign deallocValid[i] = pop;
    assign stagedCount[i] = CountWidth'(reserved);

    // Nothing waits in the RAM, in flight or in the buffer
    assign popEmpty[i] = ramEmpty[i] && (reserved == '0);
  end

endmodule

//--- mfifoCtrl.sv
// ==================================================
// Multi-FIFO controller: size check, push control,
// pointer management and pop control together
// ==================================================
`timescale 1ns/1ps

module mfifoCtrl #(
  parameter int NumFifos = 2,
  parameter int Depth = 2,
  parameter int Width = 1,
  parameter int StagingBufferDepth = 1,
  parameter int RamReadLatency = 0,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int CountWidth = mfifoPkg::countWidthF(Depth),
  localparam int FifoIdWidth = mfifoPkg::clampedClog2(NumFifos)
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [NumFifos-1:0][AddrWidth-1:0] configBase,
  input  logic [NumFifos-1:0][AddrWidth-1:0] configBound,
  output logic                                configError,
  input  logic                                pushValid,
  input  logic [FifoIdWidth-1:0]              pushFifoId,
  input  logic [Width-1:0]                    pushData,
  output logic [NumFifos-1:0]                 pushCredit,
  output logic [NumFifos-1:0]                 pushFull,
  input  logic [NumFifos-1:0]                 popReady,
  output logic [NumFifos-1:0]                 popValid,
  output logic [NumFifos-1:0][Width-1:0]     popData,
  output logic [NumFifos-1:0]                 popEmpty,
  output logic                                ramWrValid,
  output logic [AddrWidth-1:0]                ramWrAddr,
  output logic [Width-1:0]                    ramWrData,
  output logic                                ramRdAddrValid,
  output logic [AddrWidth-1:0]                ramRdAddr,
  input  logic                                ramRdDataValid,
  input  logic [Width-1:0]                    ramRdData
);

  logic [NumFifos-1:0][CountWidth-1:0] configSize;
  logic [NumFifos-1:0]                  advanceTail;
  logic [NumFifos-1:0][AddrWidth-1:0]  tail;
  logic [NumFifos-1:0]                  deallocValid;
  logic [NumFifos-1:0]                  headValid;
  logic [NumFifos-1:0]                  headReady;
  logic [NumFifos-1:0][AddrWidth-1:0]  head;
  logic [NumFifos-1:0]                  ramEmpty;
  logic [NumFifos-1:0][CountWidth-1:0] stagedCount;

  mfifoSizeCalc #(
    .NumFifos(NumFifos),
    .Depth(Depth)
  ) sizeCalc (
    .clk(clk),
    .reset(reset),
    .configBase(configBase),
    .configBound(configBound),
    .configSize(configSize),
    .configError(configError)
  );

  // Writes land at the tail of the FIFO named by the push
  mfifoPushCtrl #(
    .NumFifos(NumFifos),
    .Depth(Depth),
    .Width(Width)
  ) pushCtrl (
    .clk(clk),
    .reset(reset),
    .pushValid(pushValid),
    .pushFifoId(pushFifoId),
    .pushData(pushData),
    .deallocValid(deallocValid),
    .tail(tail),
    .pushCredit(pushCredit),
    .ramWrValid(ramWrValid),
    .ramWrAddr(ramWrAddr),
    .ramWrData(ramWrData),
    .advanceTail(advanceTail)
  );

  mfifoPtrMgr #(
    .NumFifos(NumFifos),
    .Depth(Depth)
  ) ptrMgr (
    .clk(clk),
    .reset(reset),
    .configBase(configBase),
    .configBound(configBound),
    .configSize(configSize),
    .advanceTail(advanceTail),
    .headReady(headReady),
    .stagedCount(stagedCount),
    .tail(tail),
    .head(head),
    .headValid(headValid),
    .pushFull(pushFull),
    .ramEmpty(ramEmpty)
  );

  // Reads leave the head of each FIFO and refill its staging buffer
  mfifoPopCtrl #(
    .NumFifos(NumFifos),
    .Depth(Depth),
    .Width(Width),
    .StagingBufferDepth(StagingBufferDepth),
    .RamReadLatency(RamReadLatency)
  ) popCtrl (
    .clk(clk),
    .reset(reset),
    .headValid(headValid),
    .head(head),
    .ramEmpty(ramEmpty),
    .popReady(popReady),
    .ramRdDataValid(ramRdDataValid),
    .ramRdData(ramRdData),
    .headReady(headReady),
    .stagedCount(stagedCount),
    .popValid(popValid),
    .popData(popData),
    .popEmpty(popEmpty),
    .deallocValid(deallocValid),
    .ramRdAddrValid(ramRdAddrValid),
    .ramRdAddr(ramRdAddr)
  );

endmodule

//--- mfifoRam.sv
// ==================================================
// Data RAM with one write port and one read port
// whose read latency is a parameter
// ==================================================
`timescale 1ns/1ps

module mfifoRam #(
  parameter int Depth = 2,
  parameter int Width = 1,
  parameter int RamReadLatency = 0,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth)
) (
  input  logic                 clk,
  input  logic                 wrValid,
  input  logic [AddrWidth-1:0] wrAddr,
  input  logic [Width-1:0]     wrData,
  input  logic                 rdAddrValid,
  input  logic [AddrWidth-1:0] rdAddr,
  output logic                 rdDataValid,
  output logic [Width-1:0]     rdData
);

  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  if (RamReadLatency == 0) begin : gCombRead
    // Zero latency reads the array in the same cycle
    assign rdDataValid = rdAddrValid;
    assign rdData = mem[rdAddr];
  end else begin : gPipeRead
    logic [RamReadLatency-1:0]            validPipe;
    logic [RamReadLatency-1:0][Width-1:0] dataPipe;

    // Read data and its valid step through one register per cycle of latency
    always_ff @(posedge clk) begin
      validPipe[0] <= rdAddrValid;
      dataPipe[0] <= mem[rdAddr];
      for (int s = 1; s < RamReadLatency; s++) begin
        validPipe[s] <= validPipe[s-1];
        dataPipe[s] <= dataPipe[s-1];
      end
    end

    assign rdDataValid = validPipe[RamReadLatency-1];
    assign rdData = dataPipe[RamReadLatency-1];
  end

endmodule

//--- mfifoTop.sv
// ==================================================
// Shared-storage multi-FIFO: the controller and
// its data RAM
// ==================================================
`timescale 1ns/1ps

module mfifoTop #(
  parameter int NumFifos = mfifoPkg::DefaultNumFifos,
  parameter int Depth = mfifoPkg::DefaultDepth,
  parameter int Width = mfifoPkg::DefaultWidth,
  parameter int StagingBufferDepth = mfifoPkg::DefaultStagingDepth,
  parameter int RamReadLatency = mfifoPkg::DefaultRamReadLatency,
  localparam int AddrWidth = mfifoPkg::clampedClog2(Depth),
  localparam int FifoIdWidth = mfifoPkg::clampedClog2(NumFifos)
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [NumFifos-1:0][AddrWidth-1:0] configBase,
  input  logic [NumFifos-1:0][AddrWidth-1:0] configBound,
  output logic                                configError,
  input  logic                                pushValid,
  input  logic [FifoIdWidth-1:0]              pushFifoId,
  input  logic [Width-1:0]                    pushData,
  output logic [NumFifos-1:0]                 pushCredit,
  output logic [NumFifos-1:0]                 pushFull,
  input  logic [NumFifos-1:0]                 popReady,
  output logic [NumFifos-1:0]                 popValid,
  output logic [NumFifos-1:0][Width-1:0]     popData,
  output logic [NumFifos-1:0]                 popEmpty
);

  logic                 ramWrValid;
  logic [AddrWidth-1:0] ramWrAddr;
  logic [Width-1:0]     ramWrData;
  logic                 ramRdAddrValid;
  logic [AddrWidth-1:0] ramRdAddr;
  logic                 ramRdDataValid;
  logic [Width-1:0]     ramRdData;

  mfifoCtrl #(
    .NumFifos(NumFifos),
    .Depth(Depth),
    .Width(Width),
    .StagingBufferDepth(StagingBufferDepth),
    .RamReadLatency(RamReadLatency)
  ) ctrl (
    .clk(clk),
    .reset(reset),
    .configBase(configBase),
    .configBound(configBound),
    .configError(configError),
    .pushValid(pushValid),
    .pushFifoId(pushFifoId),
    .pushData(pushData),
    .pushCredit(pushCredit),
    .pushFull(pushFull),
    .popReady(popReady),
    .popValid(popValid),
    .popData(popData),
    .popEmpty(popEmpty),
    .ramWrValid(ramWrValid),
    .ramWrAddr(ramWrAddr),
    .ramWrData(ramWrData),
    .ramRdAddrValid(ramRdAddrValid),
    .ramRdAddr(ramRdAddr),
    .ramRdDataValid(ramRdDataValid),
    .ramRdData(ramRdData)
  );

  // The controller expects read data exactly RamReadLatency cycles on
  mfifoRam #(
    .Depth(Depth),
    .Width(Width),
    .RamReadLatency(RamReadLatency)
  ) ram (
    .clk(clk),
    .wrValid(ramWrValid),
    .wrAddr(ramWrAddr),
    .wrData(ramWrData),
    .rdAddrValid(ramRdAddrValid),
    .rdAddr(ramRdAddr),
    .rdDataValid(ramRdDataValid),
    .rdData(ramRdData)
  );

endmodule

//--- mfifoTb_asserts.sv
// ==================================================
// Protocol assertions for the multi-FIFO top level
// ==================================================
`timescale 1ns/1ps

module mfifoTb_asserts #(
  parameter int NumFifos = 2,
  parameter int Width = 1,
  localparam int FifoIdWidth = mfifoPkg::clampedClog2(NumFifos)
) (
  input logic                            clk,
  input logic                            reset,
  input logic                            pushValid,
  input logic [FifoIdWidth-1:0]          pushFifoId,
  input logic [NumFifos-1:0]             pushFull,
  input logic [NumFifos-1:0]             pushCredit,
  input logic [NumFifos-1:0]             popValid,
  input logic [NumFifos-1:0]             popReady,
  input logic [NumFifos-1:0][Width-1:0] popData,
  input logic [NumFifos-1:0]             popEmpty,
  input logic                            ramWrValid,
  input logic                            ramRdAddrValid
);

  // Number of assertion failures, read by the testbench for its report
  int failCount = 0;

  // One cycle into reset every control output is idle and all FIFOs are empty
  resetIdle: assert property (@(posedge clk)
    reset |=> popValid == '0 && pushCredit == '0 && popEmpty == '1 &&
              !ramWrValid && !ramRdAddrValid)
  else begin
    failCount++;
    $error("control outputs are active or a FIFO is not empty after reset");
  end

  // A credited sender never pushes into a FIFO that is already full
  pushNotFull: assert property (@(posedge clk) disable iff (reset)
    pushValid |-> !pushFull[pushFifoId])
  else begin
    failCount++;
    $error("push arrived at full FIFO %0d", pushFifoId);
  end

  // Pushes with a known ID reach the RAM and pushes with a bad ID are dropped
  pushIdWrite: assert property (@(posedge clk) disable iff (reset)
    pushValid |-> (ramWrValid == (int'(pushFifoId) < NumFifos)))
  else begin
    failCount++;
    $error("RAM write does not match the ID of the push");
  end

  for (genvar i = 0; i < NumFifos; i++) begin : gFifo
    // Each pop transfer returns exactly one credit on the next cycle
    creditAfterPop: assert property (@(posedge clk) disable iff (reset)
      popValid[i] && popReady[i] |=> pushCredit[i])
    else begin
      failCount++;
      $error("FIFO %0d returned no credit after a pop", i);
    end

    noCreditWithoutPop: assert property (@(posedge clk) disable iff (reset)
      !(popValid[i] && popReady[i]) |=> !pushCredit[i])
    else begin
      failCount++;
      $error("FIFO %0d returned a credit without a pop", i);
    end

    // A stalled pop keeps its word on the port until it is taken
    popHold: assert property (@(posedge clk) disable iff (reset)
      popValid[i] && !popReady[i] |=> popValid[i] && $stable(popData[i]))
    else begin
      failCount++;
      $error("FIFO %0d dropped or changed its pop word under back-pressure", i);
    end
  end

endmodule

bind mfifoTop mfifoTb_asserts #(
  .NumFifos(NumFifos),
  .Width(Width)
) checks (
  .clk(clk),
  .reset(reset),
  .pushValid(pushValid),
  .pushFifoId(pushFifoId),
  .pushFull(pushFull),
  .pushCredit(pushCredit),
  .popValid(popValid),
  .popReady(popReady),
  .popData(popData),
  .popEmpty(popEmpty),
  .ramWrValid(ramWrValid),
  .ramRdAddrValid(ramRdAddrValid)
);

//--- mfifoTb.sv
// ==================================================
// Testbench for the shared-storage multi-FIFO with
// credited pushes, random pops and a scoreboard
// ==================================================
`timescale 1ns/1ps

module mfifoTb;

  import mfifoPkg::*;

  localparam int NumFifos = DefaultNumFifos;
  localparam int Depth = DefaultDepth;
  localparam int Width = DefaultWidth;
  localparam int AddrWidth = clampedClog2(Depth);
  localparam int IdWidth = clampedClog2(NumFifos);
  localparam int ResetCycles = 10;
  localparam int TrafficCycles = 800;
  localparam int PressureCycles = 250;
  localparam int DrainCycles = 250;
  localparam int HoldFifo = 1;
  localparam int ExpSlots = 256;
  // Three times the summed phase lengths plus a little slack for settling
  localparam int TimeoutCycles =
    3 * (2 * ResetCycles + TrafficCycles + PressureCycles + DrainCycles + 20);

  logic clk;
  logic reset;
  logic [NumFifos-1:0][AddrWidth-1:0] configBase;
  logic [NumFifos-1:0][AddrWidth-1:0] configBound;
  logic configError;
  logic pushValid;
  logic [IdWidth-1:0] pushFifoId;
  logic [Width-1:0] pushData;
  logic [NumFifos-1:0] pushCredit;
  logic [NumFifos-1:0] pushFull;
  logic [NumFifos-1:0] popReady;
  logic [NumFifos-1:0] popValid;
  logic [NumFifos-1:0][Width-1:0] popData;
  logic [NumFifos-1:0] popEmpty;

  // Sender credits and window sizes as the sender works them out itself
  int credits [NumFifos];
  int sizes [NumFifos];
  // Expected words per FIFO in push order
  logic [Width-1:0] expMem [NumFifos][ExpSlots];
  int expWr [NumFifos];
  int expRd [NumFifos];
  int popCount [NumFifos];
  logic [31:0] rngState;
  int cycleCount = 0;
  int dataErrors = 0;
  int checkErrors = 0;

  mfifoTop dut_i (
    .clk(clk),
    .reset(reset),
    .configBase(configBase),
    .configBound(configBound),
    .configError(configError),
    .pushValid(pushValid),
    .pushFifoId(pushFifoId),
    .pushData(pushData),
    .pushCredit(pushCredit),
    .pushFull(pushFull),
    .popReady(popReady),
    .popValid(popValid),
    .popData(popData),
    .popEmpty(popEmpty)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic nextRandom(output logic [31:0] value);
    rngState = xorshift(rngState);
    value = rngState;
  endtask

  task automatic reportCounts();
    $display("Errors: data %0d, checks %0d, assertions %0d",
             dataErrors, checkErrors, dut_i.checks.failCount);
  endtask

  task automatic expectValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got == expected) else begin
      $display("[FAIL] %s expected %h got %h", name, expected, got);
      checkErrors++;
    end
  endtask

  // Load windows 0 to 5, 6 to 7, 8 to 10 and 11 to 15, or move FIFO 1 down onto FIFO 0
  task automatic loadWindows(input bit overlap);
    configBase[0] = AddrWidth'(0);
    configBound[0] = AddrWidth'(5);
    configBase[1] = AddrWidth'(overlap ? 4 : 6);
    configBound[1] = AddrWidth'(7);
    configBase[2] = AddrWidth'(8);
    configBound[2] = AddrWidth'(10);
    configBase[3] = AddrWidth'(11);
    configBound[3] = AddrWidth'(15);
    for (int i = 0; i < NumFifos; i++) begin
      sizes[i] = int'(configBound[i]) - int'(configBase[i]) + 1;
      credits[i] = sizes[i];
      expWr[i] = 0;
      expRd[i] = 0;
      popCount[i] = 0;
    end
  endtask

  task automatic applyReset();
    reset = 1'b1;
    pushValid = 1'b0;
    popReady = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // Tag each word with its FIFO so a word in the wrong FIFO cannot match
  task automatic pushWord(input int fifo);
    logic [31:0] rnd;
    nextRandom(rnd);
    pushValid = 1'b1;
    pushFifoId = IdWidth'(fifo);
    pushData = {IdWidth'(fifo), rnd[Width-IdWidth-1:0]};
    expMem[fifo][expWr[fifo] % ExpSlots] = pushData;
    expWr[fifo]++;
    credits[fifo]--;
  endtask

  // Drive one clock of random pop readiness and at most one credited push
  task automatic stepCycle(input bit doPush, input bit readyAll, input int holdFifo);
    logic [31:0] rnd;
    int pick;
    @(posedge clk);
    #2;
    pushValid = 1'b0;
    nextRandom(rnd);
    for (int i = 0; i < NumFifos; i++) begin
      popReady[i] = readyAll || (rnd[2*i +: 2] != 2'b00);
      if (i == holdFifo) begin
        popReady[i] = 1'b0;
      end
    end
    if (doPush && rnd[12:11] != 2'b00) begin
      pick = int'(rnd[23:16]) % NumFifos;
      for (int k = 0; k < NumFifos; k++) begin
        if (!pushValid && credits[(pick + k) % NumFifos] > 0) begin
          pushWord((pick + k) % NumFifos);
        end
      end
    end
  endtask

  task automatic checkPop(input int fifo);
    logic [Width-1:0] expected;
    assert (expWr[fifo] != expRd[fifo]) else begin
      $display("FIFO %0d delivered a word that was never pushed", fifo);
      dataErrors++;
    end
    if (expWr[fifo] != expRd[fifo]) begin
      expected = expMem[fifo][expRd[fifo] % ExpSlots];
      assert (popData[fifo] == expected) else begin
        $display("[FAIL] popData[%0d] expected %h got %h", fifo, expected, popData[fifo]);
        dataErrors++;
      end
      expRd[fifo]++;
    end
    popCount[fifo]++;
  endtask

  function automatic int popsOutside(input int fifo);
    int total;
    total = 0;
    for (int i = 0; i < NumFifos; i++) begin
      if (i != fifo) begin
        total += popCount[i];
      end
    end
    return total;
  endfunction

  function automatic bit drained();
    bit done;
    done = (popEmpty == '1) && (popValid == '0);
    for (int i = 0; i < NumFifos; i++) begin
      if (expWr[i] != expRd[i] || credits[i] != sizes[i]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // Sample in mid-cycle where the outputs and the driven popReady are settled
  always @(negedge clk) begin
    if (!reset) begin
      for (int i = 0; i < NumFifos; i++) begin
        if (pushCredit[i]) begin
          credits[i]++;
        end
        if (popValid[i] && popReady[i]) begin
          checkPop(i);
        end
        // Credits held plus words still outstanding never exceed the window
        assert (credits[i] + expWr[i] - expRd[i] <= sizes[i]) else begin
          $display("FIFO %0d holds more credits and words than its size", i);
          checkErrors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      reportCounts();
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int waitCount;
    int othersBefore;
    rngState = 32'h6e9e;
    reset = 1'b1;
    pushValid = 1'b0;
    pushFifoId = '0;
    pushData = '0;
    popReady = '0;
    loadWindows(1'b0);
    applyReset();
    expectValue("popValid", 32'(popValid), 32'h0);
    expectValue("pushCredit", 32'(pushCredit), 32'h0);
    expectValue("popEmpty", 32'(popEmpty), 32'({NumFifos{1'b1}}));
    // The error flag settles one cycle after reset is released
    @(posedge clk);
    #2;
    expectValue("configError", 32'(configError), 32'h0);

    repeat (TrafficCycles) begin
      stepCycle(1'b1, 1'b0, -1);
    end

    // Stall one FIFO and keep the others moving
    othersBefore = popsOutside(HoldFifo);
    repeat (PressureCycles) begin
      stepCycle(1'b1, 1'b0, HoldFifo);
    end
    stepCycle(1'b0, 1'b0, HoldFifo);
    expectValue("pushFull[1]", 32'(pushFull[HoldFifo]), 32'h1);
    expectValue("credits[1]", credits[HoldFifo], 32'h0);
    assert (popsOutside(HoldFifo) > othersBefore) else begin
      $display("The other FIFOs stopped delivering while FIFO 1 was stalled");
      checkErrors++;
    end

    waitCount = 0;
    while (!drained() && waitCount < DrainCycles) begin
      stepCycle(1'b0, 1'b1, -1);
      waitCount++;
    end
    expectValue("popEmpty", 32'(popEmpty), 32'({NumFifos{1'b1}}));
    expectValue("popValid", 32'(popValid), 32'h0);
    for (int i = 0; i < NumFifos; i++) begin
      expectValue($sformatf("credits[%0d]", i), credits[i], sizes[i]);
      expectValue($sformatf("popped words[%0d]", i), expRd[i], expWr[i]);
    end

    // Overlapping windows must raise the configuration error
    loadWindows(1'b1);
    applyReset();
    @(posedge clk);
    #2;
    expectValue("configError", 32'(configError), 32'h1);

    reportCounts();
    if (dataErrors == 0 && checkErrors == 0 && dut_i.checks.failCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
mfifoPkg.sv
mfifoSizeCalc.sv
mfifoPushCtrl.sv
mfifoPtrMgr.sv
mfifoPopCtrl.sv
mfifoCtrl.sv
mfifoRam.sv
mfifoTop.sv
mfifoTb_asserts.sv
mfifoTb.sv

//--- Makefile
# Verilator build and run of the shared-storage multi-FIFO testbench
VERILATOR ?= verilator
TOP       ?= mfifoTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
